// ==== Bender.yml ====
package:
  name: decap_mem

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/decap_pkg.sv
      - rtl/pio_mem.sv
      - rtl/apb_pio_bridge.sv
      - rtl/decap_mem_rci.sv
      - rtl/decap_mem_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/decap_mem_checker.sv
      - tests/tb_decap_mem.sv

// ==== flist.f ====
+incdir+rtl
rtl/decap_pkg.sv
rtl/pio_mem.sv
rtl/apb_pio_bridge.sv
rtl/decap_mem_rci.sv
rtl/decap_mem_top.sv
tests/decap_mem_checker.sv
tests/tb_decap_mem.sv

// ==== rtl/apb_pio_bridge.sv ====
// apb register strobe bridge
`timescale 1ns/1ps
`default_nettype none
`include "decap_consts.svh"

module apb_pio_bridge
	import decap_pkg::*;
(
	input wire clk,
	input wire reset,

	// apb slave
	input wire [`PIO_ADDR_NBITS-1:0] paddr,
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire [`PIO_DATA_NBITS-1:0] pwdata,
	output logic [`PIO_DATA_NBITS-1:0] prdata,
	output logic pready,
	output logic pslverr,

	// register bus to the bank
	output pio_req_t pio,
	input wire pio_rsp_t rsp,
	input wire addr_err
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_STROBE,
		ST_WAIT
	} state_t;

	state_t state;
	logic setup;
	logic strobe_rd;
	logic strobe_wr;
	logic [`PIO_ADDR_NBITS-1:0] req_addr;
	logic [`PIO_DATA_NBITS-1:0] req_wdata;

	assign setup = psel & ~penable; // apb setup phase

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_IDLE;
			strobe_rd <= 1'b0;
			strobe_wr <= 1'b0;
		end else begin
			strobe_rd <= 1'b0; // one-cycle pulse
			strobe_wr <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (setup) begin
						strobe_rd <= ~pwrite;
						strobe_wr <= pwrite;
						state <= ST_STROBE;
					end
				end
				ST_STROBE: state <= ST_WAIT;
				ST_WAIT: begin
					if (rsp.ack)
						state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// address and data held for the whole transfer
	always_ff @(posedge clk) begin
		if (state == ST_IDLE && setup) begin
			req_addr <= paddr;
			req_wdata <= pwdata;
		end
	end

	assign pio = '{rd: strobe_rd, wr: strobe_wr, addr: req_addr, wdata: req_wdata};

	assign pready = (state == ST_WAIT) & rsp.ack;
	assign prdata = rsp.rdata;
	assign pslverr = pready & addr_err; // decode error from the bank

endmodule

`default_nettype wire

// ==== rtl/decap_consts.svh ====
// decap memory constants
`ifndef DECAP_CONSTS_SVH
`define DECAP_CONSTS_SVH

// host register bus
`define PIO_DATA_NBITS 32
`define PIO_ADDR_NBITS 16

// rci hash tables
`define RCI_HASH_DEPTH_NBITS 6 // 64 buckets per table
`define RCI_BUCKET_NBITS 48

// rci value table
`define RCI_VALUE_DEPTH_NBITS 5 // 32 entries
`define RCI_VALUE_NBITS 160
`define RCI_SLICE_NBITS 64 // full slice of two host words

// ###########################################################################
// host address map
// ###########################################################################
`define RCI_REGION_BIT 15 // 0 hash, 1 value
`define RCI_TABLE_BIT 9 // hash table 0 or 1
`define RCI_SLICE_LSB 3 // two-bit slice field

`endif

// ==== rtl/decap_mem_rci.sv ====
// rci lookup memory bank
`timescale 1ns/1ps
`default_nettype none
`include "decap_consts.svh"

module decap_mem_rci
	import decap_pkg::*;
(
	input wire clk,
	input wire reset,

	input wire pio_req_t pio,
	input wire hash_req_t hash0_req,
	input wire hash_req_t hash1_req,
	input wire value_req_t value_req,

	output pio_rsp_t rsp,
	output logic addr_err,
	output hash_rsp_t hash0_rsp,
	output hash_rsp_t hash1_rsp,
	output value_rsp_t value_rsp
);

	logic region; // 1 selects value slices
	logic table_sel;
	logic [1:0] slice;
	logic sel_hash0;
	logic sel_hash1;
	logic sel_slice0;
	logic sel_slice1;
	logic sel_slice2;
	logic err_ack;
	pio_req_t value_pio;

	pio_rsp_t hash0_pio_rsp;
	pio_rsp_t hash1_pio_rsp;
	pio_rsp_t slice0_pio_rsp;
	pio_rsp_t slice1_pio_rsp;
	pio_rsp_t slice2_pio_rsp;

	logic hash0_ack;
	logic hash1_ack;
	logic slice0_ack;
	bucket_t hash0_bucket;
	bucket_t hash1_bucket;
	slice_t slice0_data;
	slice_t slice1_data;
	slice_tail_t slice2_data;

	// ###########################################################################
	// host address decode
	// ###########################################################################
	assign region = pio.addr[`RCI_REGION_BIT];
	assign table_sel = pio.addr[`RCI_TABLE_BIT];
	assign slice = pio.addr[`RCI_SLICE_LSB+1:`RCI_SLICE_LSB];

	assign sel_hash0 = ~region & ~table_sel;
	assign sel_hash1 = ~region & table_sel;
	assign sel_slice0 = region & (slice == 2'd0);
	assign sel_slice1 = region & (slice == 2'd1);
	assign sel_slice2 = region & (slice == 2'd2);
	assign addr_err = region & (slice == 2'd3);

	// slice field squeezed out so the entry index lands on bit 3
	always_comb begin
		value_pio = pio;
		value_pio.addr = {2'b00, pio.addr[`PIO_ADDR_NBITS-1:`RCI_SLICE_LSB+2],
			pio.addr[`RCI_SLICE_LSB-1:0]};
	end

	// no memory answers a bad address
	always_ff @(posedge clk) begin
		if (reset)
			err_ack <= 1'b0;
		else
			err_ack <= (pio.rd | pio.wr) & addr_err;
	end

	// ###########################################################################
	// memories
	// ###########################################################################
	pio_mem #(.PAYLOAD_T(bucket_t), .DEPTH_NBITS(`RCI_HASH_DEPTH_NBITS)) u_hash0 (
		.clk(clk),
		.reset(reset),
		.pio(pio),
		.sel(sel_hash0),
		.app_rd(hash0_req.rd),
		.app_raddr(hash0_req.raddr),
		.rsp(hash0_pio_rsp),
		.app_ack(hash0_ack),
		.app_rdata(hash0_bucket)
	);

	pio_mem #(.PAYLOAD_T(bucket_t), .DEPTH_NBITS(`RCI_HASH_DEPTH_NBITS)) u_hash1 (
		.clk(clk),
		.reset(reset),
		.pio(pio),
		.sel(sel_hash1),
		.app_rd(hash1_req.rd),
		.app_raddr(hash1_req.raddr),
		.rsp(hash1_pio_rsp),
		.app_ack(hash1_ack),
		.app_rdata(hash1_bucket)
	);

	pio_mem #(.PAYLOAD_T(slice_t), .DEPTH_NBITS(`RCI_VALUE_DEPTH_NBITS)) u_slice0 (
		.clk(clk),
		.reset(reset),
		.pio(value_pio),
		.sel(sel_slice0),
		.app_rd(value_req.rd),
		.app_raddr(value_req.raddr),
		.rsp(slice0_pio_rsp),
		.app_ack(slice0_ack), // stands for the whole entry
		.app_rdata(slice0_data)
	);

	pio_mem #(.PAYLOAD_T(slice_t), .DEPTH_NBITS(`RCI_VALUE_DEPTH_NBITS)) u_slice1 (
		.clk(clk),
		.reset(reset),
		.pio(value_pio),
		.sel(sel_slice1),
		.app_rd(value_req.rd),
		.app_raddr(value_req.raddr),
		.rsp(slice1_pio_rsp),
		.app_ack(),
		.app_rdata(slice1_data)
	);

	pio_mem #(.PAYLOAD_T(slice_tail_t), .DEPTH_NBITS(`RCI_VALUE_DEPTH_NBITS)) u_slice2 (
		.clk(clk),
		.reset(reset),
		.pio(value_pio),
		.sel(sel_slice2),
		.app_rd(value_req.rd),
		.app_raddr(value_req.raddr),
		.rsp(slice2_pio_rsp),
		.app_ack(),
		.app_rdata(slice2_data)
	);

	// ###########################################################################
	// responses
	// ###########################################################################
	always_comb begin
		rsp = '0;
		if (addr_err) begin
			rsp.ack = err_ack; // rdata stays 0
		end else if (!region) begin
			rsp = table_sel ? hash1_pio_rsp : hash0_pio_rsp;
		end else begin
			case (slice)
				2'd0: rsp = slice0_pio_rsp;
				2'd1: rsp = slice1_pio_rsp;
				default: rsp = slice2_pio_rsp;
			endcase
		end
	end

	assign hash0_rsp = '{ack: hash0_ack, bucket: hash0_bucket};
	assign hash1_rsp = '{ack: hash1_ack, bucket: hash1_bucket};
	assign value_rsp = '{ack: slice0_ack,
		value: '{slice2: slice2_data, slice1: slice1_data, slice0: slice0_data}};

endmodule

`default_nettype wire

// ==== rtl/decap_mem_top.sv ====
// decap lookup memory top
`timescale 1ns/1ps
`default_nettype none
`include "decap_consts.svh"

module decap_mem_top
	import decap_pkg::*;
(
	input wire clk,
	input wire reset,

	// host apb
	input wire [`PIO_ADDR_NBITS-1:0] paddr,
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire [`PIO_DATA_NBITS-1:0] pwdata,
	output logic [`PIO_DATA_NBITS-1:0] prdata,
	output logic pready,
	output logic pslverr,

	// lookup clients
	input wire hash_req_t hash0_req,
	input wire hash_req_t hash1_req,
	input wire value_req_t value_req,
	output hash_rsp_t hash0_rsp,
	output hash_rsp_t hash1_rsp,
	output value_rsp_t value_rsp
);

	pio_req_t pio;
	pio_rsp_t pio_rsp;
	logic addr_err;

	apb_pio_bridge u_bridge (
		.clk(clk),
		.reset(reset),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.pio(pio),
		.rsp(pio_rsp),
		.addr_err(addr_err)
	);

	decap_mem_rci u_rci (
		.clk(clk),
		.reset(reset),
		.pio(pio),
		.hash0_req(hash0_req),
		.hash1_req(hash1_req),
		.value_req(value_req),
		.rsp(pio_rsp),
		.addr_err(addr_err),
		.hash0_rsp(hash0_rsp),
		.hash1_rsp(hash1_rsp),
		.value_rsp(value_rsp)
	);

endmodule

`default_nettype wire

// ==== rtl/decap_pkg.sv ====
// decap memory types
`default_nettype none
`include "decap_consts.svh"

package decap_pkg;

	// register strobe from the bridge
	typedef struct packed {
		logic rd;
		logic wr;
		logic [`PIO_ADDR_NBITS-1:0] addr;
		logic [`PIO_DATA_NBITS-1:0] wdata;
	} pio_req_t;

	typedef struct packed {
		logic ack;
		logic [`PIO_DATA_NBITS-1:0] rdata;
	} pio_rsp_t;

	// ###########################################################################
	// payloads
	// ###########################################################################
	typedef logic [`RCI_BUCKET_NBITS-1:0] bucket_t;
	typedef logic [`RCI_SLICE_NBITS-1:0] slice_t;
	typedef logic [`RCI_VALUE_NBITS-2*`RCI_SLICE_NBITS-1:0] slice_tail_t;

	typedef struct packed {
		slice_tail_t slice2; // top bits of the entry
		slice_t slice1;
		slice_t slice0; // low bits
	} value_t;

	// lookup ports
	typedef struct packed {
		logic rd;
		logic [`RCI_HASH_DEPTH_NBITS-1:0] raddr;
	} hash_req_t;

	typedef struct packed {
		logic ack;
		bucket_t bucket;
	} hash_rsp_t;

	typedef struct packed {
		logic rd;
		logic [`RCI_VALUE_DEPTH_NBITS-1:0] raddr;
	} value_req_t;

	typedef struct packed {
		logic ack;
		value_t value;
	} value_rsp_t;

endpackage

`default_nettype wire

// ==== rtl/pio_mem.sv ====
// host-accessible lookup memory
`timescale 1ns/1ps
`default_nettype none
`include "decap_consts.svh"

module pio_mem
	import decap_pkg::*;
#(
	parameter type PAYLOAD_T = bucket_t,
	parameter int DEPTH_NBITS = `RCI_HASH_DEPTH_NBITS
) (
	input wire clk,
	input wire reset,

	// host word access
	input wire pio_req_t pio,
	input wire sel,

	// lookup read port
	input wire app_rd,
	input wire [DEPTH_NBITS-1:0] app_raddr,

	output pio_rsp_t rsp,
	output logic app_ack,
	output PAYLOAD_T app_rdata
);

	localparam int PAYLOAD_NBITS = $bits(PAYLOAD_T);
	localparam int ENTRY_NBITS = 2*`PIO_DATA_NBITS; // entry seen as two host words

	PAYLOAD_T mem [2**DEPTH_NBITS];

	logic [DEPTH_NBITS-1:0] host_idx;
	logic host_hi; // high word of the entry
	logic host_rd;
	logic host_wr;
	logic [ENTRY_NBITS-1:0] host_entry;
	logic [ENTRY_NBITS-1:0] host_merged;
	logic host_ack;
	logic [`PIO_DATA_NBITS-1:0] host_rdata;

	assign host_idx = pio.addr[DEPTH_NBITS+2:3];
	assign host_hi = pio.addr[2];
	assign host_rd = sel & pio.rd;
	assign host_wr = sel & pio.wr;

	// ###########################################################################
	// host word merge
	// ###########################################################################
	always_comb begin
		host_entry = ENTRY_NBITS'(mem[host_idx]); // bits above payload read as zero
		host_merged = host_entry;
		if (host_hi)
			host_merged[ENTRY_NBITS-1 -: `PIO_DATA_NBITS] = pio.wdata;
		else
			host_merged[`PIO_DATA_NBITS-1:0] = pio.wdata;
	end

	// single write port on the host side
	always_ff @(posedge clk) begin
		if (host_wr)
			mem[host_idx] <= PAYLOAD_T'(host_merged[PAYLOAD_NBITS-1:0]);
	end

	// ###########################################################################
	// read ports
	// ###########################################################################
	always_ff @(posedge clk) begin
		if (host_rd) begin
			if (host_hi)
				host_rdata <= host_entry[ENTRY_NBITS-1 -: `PIO_DATA_NBITS];
			else
				host_rdata <= host_entry[`PIO_DATA_NBITS-1:0];
		end
		if (app_rd)
			app_rdata <= mem[app_raddr]; // old data on a same-cycle write
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			host_ack <= 1'b0;
			app_ack <= 1'b0;
		end else begin
			host_ack <= host_rd | host_wr; // writes are acked too
			app_ack <= app_rd;
		end
	end

	assign rsp = '{ack: host_ack, rdata: host_rdata};

endmodule

`default_nettype wire

// ==== tests/decap_mem_checker.sv ====
// decap memory result checker
`timescale 1ns/1ps
`default_nettype none
`include "decap_consts.svh"

module decap_mem_checker
	import decap_pkg::*;
#(
	parameter int NAME_NBITS = 8*24
) (
	input wire clk,
	input wire reset,

	// dut outputs
	input wire [`PIO_DATA_NBITS-1:0] prdata,
	input wire pready,
	input wire pslverr,
	input wire hash_rsp_t hash0_rsp,
	input wire hash_rsp_t hash1_rsp,
	input wire value_rsp_t value_rsp,

	// test announced by the stimulus side
	input wire exp_valid,
	input wire [NAME_NBITS-1:0] exp_name,
	input wire [31:0] exp_kind,
	input wire [`RCI_VALUE_NBITS-1:0] exp_value,

	output int pass_count,
	output int fail_count,
	output int pending
);

	localparam logic [1:0] CH_APB = 2'd0;
	localparam logic [1:0] CH_HASH0 = 2'd1;
	localparam logic [1:0] CH_HASH1 = 2'd2;
	localparam logic [1:0] CH_VALUE = 2'd3;
	localparam int RESPONSE_LIMIT = 8; // cycles

	typedef struct packed {
		logic [1:0] ch;
		logic [NAME_NBITS-1:0] name;
		logic [31:0] kind;
		logic [`RCI_VALUE_NBITS-1:0] exp;
		logic [3:0] age;
	} pending_t;

	pending_t pend[$]; // tests waiting for a response
	pending_t incoming;
	int pass_total = 0;
	int fail_total = 0;

	function automatic logic [1:0] channel_of(input logic [31:0] kind);
		if (kind == "h0")
			return CH_HASH0;
		if (kind == "h1")
			return CH_HASH1;
		if (kind == "val")
			return CH_VALUE;
		return CH_APB; // wr and rd
	endfunction

	function automatic string channel_name(input logic [1:0] ch);
		case (ch)
			CH_HASH0: return "hash0";
			CH_HASH1: return "hash1";
			CH_VALUE: return "value";
			default: return "apb";
		endcase
	endfunction

	// ###########################################################################
	// response matching
	// ###########################################################################
	task automatic check_channel(input logic [1:0] ch, input logic seen,
		input logic [`RCI_VALUE_NBITS-1:0] actual);
		int idx;
		pending_t p;
		logic [`RCI_VALUE_NBITS-1:0] act;
		if (seen) begin
			idx = 0;
			while (idx < pend.size() && pend[idx].ch != ch)
				idx++;
			if (idx == pend.size()) begin
				$display("unexpected %s response while no test was waiting", channel_name(ch));
				fail_total++;
			end else begin
				p = pend[idx];
				pend.delete(idx);
				act = actual;
				if (p.kind == "wr")
					act = actual >> `PIO_DATA_NBITS; // pslverr only
				if (ch != CH_APB && p.age != 0) begin
					$display("%0s: %s ack came %0d cycles late", p.name, channel_name(ch), p.age);
					fail_total++;
				end else if (act !== p.exp) begin
					$display("Fail %0s expected %0h actual %0h", p.name, p.exp, act);
					fail_total++;
				end else begin
					$display("ok   %0s", p.name);
					pass_total++;
				end
			end
		end
	endtask

	task automatic age_pending();
		int i;
		for (i = pend.size() - 1; i >= 0; i--) begin
			pend[i].age = pend[i].age + 4'd1;
			if (pend[i].age > RESPONSE_LIMIT) begin
				if (pend[i].ch == CH_APB)
					$display("%0s: no pready within %0d cycles", pend[i].name, RESPONSE_LIMIT);
				else
					$display("%0s: no %s ack within %0d cycles", pend[i].name,
						channel_name(pend[i].ch), RESPONSE_LIMIT);
				fail_total++;
				pend.delete(i);
			end
		end
	endtask

	always @(posedge clk) begin
		if (reset) begin
			pend.delete();
		end else begin
			check_channel(CH_APB, pready, {pslverr, prdata});
			check_channel(CH_HASH0, hash0_rsp.ack, hash0_rsp.bucket);
			check_channel(CH_HASH1, hash1_rsp.ack, hash1_rsp.bucket);
			check_channel(CH_VALUE, value_rsp.ack, value_rsp.value);
			age_pending();
			if (exp_valid) begin
				incoming.ch = channel_of(exp_kind);
				incoming.name = exp_name;
				incoming.kind = exp_kind;
				incoming.exp = exp_value;
				incoming.age = '0;
				pend.push_back(incoming);
			end
		end
		pass_count <= pass_total; // seen by the testbench after the edge
		fail_count <= fail_total;
		pending <= pend.size();
	end

endmodule

`default_nettype wire

// ==== tests/decap_mem_patterns.txt ====
# name kind addr data expected, all numbers in hex
# wr/rd is an apb access at byte addr; expected is pslverr for wr, {pslverr, prdata} for rd
# h0/h1/val is a lookup of entry addr; expected is the returned bucket or value entry
h0_b5_wr_lo wr 0028 11112222 0
h0_b5_wr_hi wr 002c abcd3344 0
h1_b5_wr_lo wr 0228 55556666 0
h1_b5_wr_hi wr 022c 00007777 0
h0_b5_rd_lo rd 0028 0 011112222
h0_b5_rd_hi rd 002c 0 000003344
h1_b5_rd_lo rd 0228 0 055556666
h1_b5_rd_hi rd 022c 0 000007777
h0_b5_lookup h0 05 0 334411112222
h1_b5_lookup h1 05 0 777755556666
h0_b6_wr_lo wr 0030 87654321 0
h0_b6_wr_hi wr 0034 0000cafe 0
h0_b6_lookup h0 06 0 cafe87654321
h0_b6_wr_new wr 0030 0badf00d 0
h0_b6_relook h0 06 0 cafe0badf00d
h0_b2b_b5 h0 05 0 334411112222
h0_b2b_b6 h0 06 0 cafe0badf00d
h0_b2b_b5_again h0 05 0 334411112222
v3_s0_wr_lo wr 8060 a0a0a0a0 0
v3_s0_wr_hi wr 8064 b1b1b1b1 0
v3_s1_wr_lo wr 8068 c2c2c2c2 0
v3_s1_wr_hi wr 806c d3d3d3d3 0
v3_s2_wr_lo wr 8070 e4e4e4e4 0
v3_lookup val 03 0 e4e4e4e4d3d3d3d3c2c2c2c2b1b1b1b1a0a0a0a0
v3_s3_wr wr 8078 ffffffff 1
v3_s3_rd rd 8078 0 100000000
v3_s0_rd_lo rd 8060 0 0a0a0a0a0
v3_s2_rd_hi rd 8074 0 000000000
v3_relook val 03 0 e4e4e4e4d3d3d3d3c2c2c2c2b1b1b1b1a0a0a0a0

// ==== tests/tb_decap_mem.sv ====
// decap memory testbench
`timescale 1ns/1ps
`default_nettype none
`include "decap_consts.svh"

module tb_decap_mem
	import decap_pkg::*;
();

	localparam int CLK_PERIOD = 40;
	localparam int NAME_NBITS = 8*24;
	localparam string PATTERN_FILE = "tests/decap_mem_patterns.txt";

	typedef struct packed {
		logic [NAME_NBITS-1:0] name;
		logic [31:0] kind; // wr, rd, h0, h1 or val
		logic [`PIO_ADDR_NBITS-1:0] addr;
		logic [`PIO_DATA_NBITS-1:0] data;
		logic [`RCI_VALUE_NBITS-1:0] exp;
	} pattern_t;

	logic clk;
	logic reset;
	logic [`PIO_ADDR_NBITS-1:0] paddr;
	logic psel;
	logic penable;
	logic pwrite;
	logic [`PIO_DATA_NBITS-1:0] pwdata;
	logic [`PIO_DATA_NBITS-1:0] prdata;
	logic pready;
	logic pslverr;
	hash_req_t hash0_req;
	hash_req_t hash1_req;
	value_req_t value_req;
	hash_rsp_t hash0_rsp;
	hash_rsp_t hash1_rsp;
	value_rsp_t value_rsp;

	logic exp_valid;
	logic [NAME_NBITS-1:0] exp_name;
	logic [31:0] exp_kind;
	logic [`RCI_VALUE_NBITS-1:0] exp_value;
	int pass_count;
	int fail_count;
	int pending;

	pattern_t patterns[$];
	int num_patterns = 0;
	logic loaded = 1'b0;
	int seed = 6347;

	decap_mem_top i_decap_mem_top (
		.clk(clk),
		.reset(reset),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.hash0_req(hash0_req),
		.hash1_req(hash1_req),
		.value_req(value_req),
		.hash0_rsp(hash0_rsp),
		.hash1_rsp(hash1_rsp),
		.value_rsp(value_rsp)
	);

	decap_mem_checker #(.NAME_NBITS(NAME_NBITS)) mem_checker (
		.clk(clk),
		.reset(reset),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.hash0_rsp(hash0_rsp),
		.hash1_rsp(hash1_rsp),
		.value_rsp(value_rsp),
		.exp_valid(exp_valid),
		.exp_name(exp_name),
		.exp_kind(exp_kind),
		.exp_value(exp_value),
		.pass_count(pass_count),
		.fail_count(fail_count),
		.pending(pending)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD/2) clk = ~clk;
	end

	// ###########################################################################
	// pattern reader and drivers
	// ###########################################################################
	task automatic load_patterns(output bit ok);
		int fd;
		int rc;
		string line;
		pattern_t p;
		logic [NAME_NBITS-1:0] name;
		logic [31:0] kind;
		logic [`PIO_ADDR_NBITS-1:0] addr;
		logic [`PIO_DATA_NBITS-1:0] data;
		logic [`RCI_VALUE_NBITS-1:0] expected;
		fd = $fopen(PATTERN_FILE, "r");
		ok = (fd != 0);
		if (ok) begin
			while (!$feof(fd)) begin
				line = "";
				rc = $fgets(line, fd);
				if (rc > 0 && line.len() > 0 && line[0] != "#") begin // skip column notes
					rc = $sscanf(line, "%s %s %h %h %h", name, kind, addr, data, expected);
					if (rc == 5) begin
						p.name = name;
						p.kind = kind;
						p.addr = addr;
						p.data = data;
						p.exp = expected;
						patterns.push_back(p);
					end
				end
			end
			$fclose(fd);
		end
		num_patterns = patterns.size();
		ok = ok && (num_patterns > 0);
	endtask

	task automatic drop_strobes();
		hash0_req <= '0;
		hash1_req <= '0;
		value_req <= '0;
		exp_valid <= 1'b0;
	endtask

	task automatic announce_test(input pattern_t p);
		exp_valid <= 1'b1;
		exp_name <= p.name;
		exp_kind <= p.kind;
		exp_value <= p.exp;
	endtask

	// setup, access, then hold until pready or give up
	task automatic apb_transfer(input pattern_t p);
		int waited;
		@(posedge clk);
		drop_strobes();
		paddr <= p.addr;
		pwdata <= p.data;
		pwrite <= (p.kind == "wr");
		psel <= 1'b1;
		penable <= 1'b0;
		announce_test(p);
		@(posedge clk);
		drop_strobes();
		penable <= 1'b1;
		waited = 0;
		@(posedge clk);
		while (!pready && waited < 8) begin
			waited++;
			@(posedge clk);
		end
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic issue_lookup(input pattern_t p);
		@(posedge clk);
		drop_strobes();
		if (p.kind == "h0") begin
			hash0_req <= '{rd: 1'b1, raddr: p.addr[`RCI_HASH_DEPTH_NBITS-1:0]};
			announce_test(p);
		end else if (p.kind == "h1") begin
			hash1_req <= '{rd: 1'b1, raddr: p.addr[`RCI_HASH_DEPTH_NBITS-1:0]};
			announce_test(p);
		end else if (p.kind == "val") begin
			value_req <= '{rd: 1'b1, raddr: p.addr[`RCI_VALUE_DEPTH_NBITS-1:0]};
			announce_test(p);
		end else begin
			$display("unknown operation %0s in test %0s", p.kind, p.name);
		end
	endtask

	// ###########################################################################
	// main sequence
	// ###########################################################################
	initial begin
		bit ok;
		int gap;
		int waited;
		reset = 1'b1;
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = '0;
		hash0_req = '0;
		hash1_req = '0;
		value_req = '0;
		exp_valid = 1'b0;
		exp_name = '0;
		exp_kind = '0;
		exp_value = '0;
		load_patterns(ok);
		if (!ok) begin
			$display("pattern file %s is missing or holds no operations", PATTERN_FILE);
			$display("Testbench failed");
			$finish;
		end else begin
			loaded = 1'b1;
			repeat (4) @(posedge clk);
			reset <= 1'b0;
			foreach (patterns[i]) begin
				if (patterns[i].kind == "wr" || patterns[i].kind == "rd") begin
					gap = $unsigned($random(seed)) % 4;
					repeat (gap) begin
						@(posedge clk);
						drop_strobes();
					end
					apb_transfer(patterns[i]);
				end else begin
					issue_lookup(patterns[i]); // lookups go out back to back
				end
			end
			@(posedge clk);
			drop_strobes();
			waited = 0;
			while ((exp_valid || pending != 0) && waited < 12) begin
				@(posedge clk);
				waited++;
			end
			$display("tests %0d  passed %0d  failed %0d", num_patterns, pass_count, fail_count);
			if (fail_count == 0 && pass_count == num_patterns) begin
				$display("Testbench passed");
			end else begin
				$display("Testbench failed");
			end
			$finish;
		end
	end

	// watchdog allows 12 cycles per pattern
	initial begin
		wait (loaded);
		#(num_patterns * 12 * CLK_PERIOD);
		$display("run stopped by the watchdog after %0d patterns' worth of time", num_patterns);
		$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire
